// ==== fm_settings.svh ====
////////////////////////////////////////
// FM mixer widths and counts
////////////////////////////////////////

`ifndef FM_SETTINGS_SVH
`define FM_SETTINGS_SVH

// Operator result width from the operator pipeline
`define FM_OP_W 14

// Sound output and accumulator width
`define FM_SND_W 16

// Channel and operator layout
`define FM_NUM_CH 6
`define FM_NUM_OP 4

// Slots in one full round, channel-major
`define FM_NUM_SLOT 24

`endif

// ==== fm_slot_pkg.sv ====
////////////////////////////////////////
// Slot and channel config types
////////////////////////////////////////

`include "fm_settings.svh"

package fm_slot_pkg;

  // Field widths derived from the channel and operator counts
  localparam int CH_W = $clog2(`FM_NUM_CH);
  localparam int OP_W = $clog2(`FM_NUM_OP);

  // Slot position, ch in the upper bits so the packed value is ch*4+op
  typedef struct packed {
    logic [CH_W-1:0] ch;
    logic [OP_W-1:0] op;
  } slot_t;

  // Output routing of one channel
  typedef struct packed {
    logic left;
    logic right;
  } pan_t;

  // Per-channel configuration
  typedef struct packed {
    logic [2:0] alg;
    pan_t       pan;
  } ch_cfg_t;

  // One-cycle configuration write
  typedef struct packed {
    logic            we;
    logic [CH_W-1:0] ch;
    ch_cfg_t         cfg;
  } cfg_wr_t;

endpackage

// ==== fm_audio_pkg.sv ====
////////////////////////////////////////
// Audio sample and frame types
////////////////////////////////////////

`include "fm_settings.svh"

package fm_audio_pkg;

  // Signed result of one operator
  typedef logic signed [`FM_OP_W-1:0] op_sample_t;

  // Held sound of one side
  typedef logic signed [`FM_SND_W-1:0] snd_t;

  // One stereo frame with clip flags of the round
  typedef struct packed {
    snd_t left;
    snd_t right;
    logic clip_l;
    logic clip_r;
  } frame_t;

endpackage

// ==== fm_slot_seq.sv ====
////////////////////////////////////////
// Slot sequencer and carrier decode
////////////////////////////////////////

`timescale 1ns/1ps

`include "fm_settings.svh"

module fm_slot_seq (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  clk_en,
  input  fm_slot_pkg::cfg_wr_t  cfg_wr,
  output fm_slot_pkg::slot_t    slot,
  output logic                  zero,
  output logic                  sum_en_l,
  output logic                  sum_en_r,
  output logic                  frame_tick
);

  localparam int SLOT_W = $bits(fm_slot_pkg::slot_t);
  localparam logic [SLOT_W-1:0] LAST_SLOT = SLOT_W'(`FM_NUM_SLOT - 1);
  localparam logic [fm_slot_pkg::OP_W-1:0] LAST_OP =
    fm_slot_pkg::OP_W'(`FM_NUM_OP - 1);

  logic [SLOT_W-1:0]    slot_idx;
  fm_slot_pkg::ch_cfg_t cfg_tbl [`FM_NUM_CH];
  fm_slot_pkg::ch_cfg_t cur_cfg;
  logic                 carrier;

  // Round counter, advances one slot per strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      slot_idx <= '0;
    end else if (clk_en) begin
      if (slot_idx == LAST_SLOT) begin
        slot_idx <= '0;
      end else begin
        slot_idx <= slot_idx + 1'b1;
      end
    end
  end

  // Channel-major order makes the counter value the packed slot
  assign slot = fm_slot_pkg::slot_t'(slot_idx);
  assign zero = (slot_idx == '0);

  // Configuration table, writes land independent of the strobe
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `FM_NUM_CH; i++) begin
        cfg_tbl[i] <= '0;
      end
    end else if (cfg_wr.we && (cfg_wr.ch < `FM_NUM_CH)) begin
      cfg_tbl[cfg_wr.ch] <= cfg_wr.cfg;
    end
  end

  assign cur_cfg = cfg_tbl[slot.ch];

  // Carrier table by algorithm
  always_comb begin
    case (cur_cfg.alg)
      3'd0, 3'd1, 3'd2, 3'd3: begin
        carrier = (slot.op == LAST_OP);
      end
      3'd4: begin
        // Ops 1 and 3
        carrier = slot.op[0];
      end
      3'd5, 3'd6: begin
        carrier = (slot.op != '0);
      end
      default: begin
        carrier = 1'b1;
      end
    endcase
  end

  assign sum_en_l = carrier && cur_cfg.pan.left;
  assign sum_en_r = carrier && cur_cfg.pan.right;

  // One cycle after the slot 0 strobe, when snd has just moved
  always_ff @(posedge clk) begin
    if (rst) begin
      frame_tick <= 1'b0;
    end else begin
      frame_tick <= clk_en && zero;
    end
  end

  // Slot 0 is left on the same edge, so a tick can never repeat
  a_tick_single: assert property (@(posedge clk) disable iff (rst)
    frame_tick |=> !frame_tick);

endmodule

// ==== fm_single_acc.sv ====
////////////////////////////////////////
// Saturating round accumulator
////////////////////////////////////////

`timescale 1ns/1ps

module fm_single_acc #(
  parameter int WIN  = 14,
  parameter int WOUT = 16
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   clk_en,
  input  logic                   sum_en,
  input  logic                   zero,
  input  logic signed [WIN-1:0]  op_result,
  output logic signed [WOUT-1:0] snd,
  output logic                   ovf
);

  localparam logic signed [WOUT-1:0] MAX_VAL = {1'b0, {(WOUT-1){1'b1}}};
  localparam logic signed [WOUT-1:0] MIN_VAL = {1'b1, {(WOUT-1){1'b0}}};

  logic signed [WOUT-1:0] acc;
  logic signed [WOUT-1:0] current;
  logic signed [WOUT-1:0] next;
  logic                   overflow;
  logic signed [WOUT:0]   wide_sum;

  // Sign-extended routed result
  assign current = sum_en ? WOUT'(op_result) : '0;

  // Slot 0 starts a new round without adding
  assign next = zero ? current : acc + current;

  // Same operand signs, different result sign
  assign overflow = !zero && (current[WOUT-1] == acc[WOUT-1]) &&
                    (next[WOUT-1] != acc[WOUT-1]);

  // Exact sum one bit wider, never wraps
  assign wide_sum = acc + current;

  always_ff @(posedge clk) begin
    if (rst) begin
      acc <= '0;
      snd <= '0;
      ovf <= 1'b0;
    end else begin
      ovf <= clk_en && overflow;
      if (clk_en) begin
        if (overflow) begin
          acc <= acc[WOUT-1] ? MIN_VAL : MAX_VAL;
        end else begin
          acc <= next;
        end
        // Old round total moves to the held output
        if (zero) begin
          snd <= acc;
        end
      end
    end
  end

  a_width: assert property (@(posedge clk) WOUT >= WIN);

  a_hold: assert property (@(posedge clk) disable iff (rst)
    !clk_en |=> (acc == $past(acc)) && (snd == $past(snd)));

  a_sat_hi: assert property (@(posedge clk) disable iff (rst)
    clk_en && !zero && (wide_sum > MAX_VAL) |=> acc == MAX_VAL);

  a_sat_lo: assert property (@(posedge clk) disable iff (rst)
    clk_en && !zero && (wide_sum < MIN_VAL) |=> acc == MIN_VAL);

  a_snd_move: assert property (@(posedge clk) disable iff (rst)
    !$stable(snd) |-> $past(clk_en && zero));

  a_no_ovf_on_zero: assert property (@(posedge clk) disable iff (rst)
    clk_en && zero |=> !ovf);

endmodule

// ==== fm_stereo_out.sv ====
////////////////////////////////////////
// Stereo frame builder
////////////////////////////////////////

`timescale 1ns/1ps

`include "fm_settings.svh"

module fm_stereo_out (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       frame_tick,
  input  logic                       ovf_l,
  input  logic                       ovf_r,
  input  logic signed [`FM_SND_W-1:0] snd_l,
  input  logic signed [`FM_SND_W-1:0] snd_r,
  output fm_audio_pkg::frame_t       frame,
  output logic                       frame_valid
);

  logic clip_l;
  logic clip_r;

  // Sticky clip flags, restart on each frame
  always_ff @(posedge clk) begin
    if (rst) begin
      clip_l <= 1'b0;
      clip_r <= 1'b0;
    end else if (frame_tick) begin
      // An ovf here already belongs to the new round
      clip_l <= ovf_l;
      clip_r <= ovf_r;
    end else begin
      clip_l <= clip_l || ovf_l;
      clip_r <= clip_r || ovf_r;
    end
  end

  // Frame payload
  always_ff @(posedge clk) begin
    if (frame_tick) begin
      frame.left   <= snd_l;
      frame.right  <= snd_r;
      frame.clip_l <= clip_l;
      frame.clip_r <= clip_r;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= frame_tick;
    end
  end

  a_valid_after_tick: assert property (@(posedge clk) disable iff (rst)
    frame_valid |-> $past(frame_tick));

endmodule

// ==== fm_acc_top.sv ====
////////////////////////////////////////
// FM output mixing stage
////////////////////////////////////////

`timescale 1ns/1ps

`include "fm_settings.svh"

module fm_acc_top (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     clk_en,
  input  fm_audio_pkg::op_sample_t op_result,
  input  fm_slot_pkg::cfg_wr_t     cfg_wr,
  output fm_audio_pkg::frame_t     frame,
  output logic                     frame_valid
);

  logic                        zero;
  logic                        sum_en_l;
  logic                        sum_en_r;
  logic                        frame_tick;
  logic signed [`FM_SND_W-1:0] snd_l;
  logic signed [`FM_SND_W-1:0] snd_r;
  logic                        ovf_l;
  logic                        ovf_r;

  // Slot position is only needed inside the sequencer
  fm_slot_seq u_seq (
    .clk        (clk),
    .rst        (rst),
    .clk_en     (clk_en),
    .cfg_wr     (cfg_wr),
    .slot       (),
    .zero       (zero),
    .sum_en_l   (sum_en_l),
    .sum_en_r   (sum_en_r),
    .frame_tick (frame_tick)
  );

  fm_single_acc #(
    .WIN  (`FM_OP_W),
    .WOUT (`FM_SND_W)
  ) acc_l (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .sum_en    (sum_en_l),
    .zero      (zero),
    .op_result (op_result),
    .snd       (snd_l),
    .ovf       (ovf_l)
  );

  fm_single_acc #(
    .WIN  (`FM_OP_W),
    .WOUT (`FM_SND_W)
  ) acc_r (
    .clk       (clk),
    .rst       (rst),
    .clk_en    (clk_en),
    .sum_en    (sum_en_r),
    .zero      (zero),
    .op_result (op_result),
    .snd       (snd_r),
    .ovf       (ovf_r)
  );

  fm_stereo_out u_out (
    .clk         (clk),
    .rst         (rst),
    .frame_tick  (frame_tick),
    .ovf_l       (ovf_l),
    .ovf_r       (ovf_r),
    .snd_l       (snd_l),
    .snd_r       (snd_r),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

endmodule

// ==== tb_fm_acc_top.sv ====
////////////////////////////////////////
// FM mixing stage testbench
////////////////////////////////////////

`timescale 1ns/1ps

`include "fm_settings.svh"

module tb_fm_acc_top;

  localparam int MAX_GAP = 5;
  // Rounds per test: reset 2, algorithms 9, pan 2, saturation 4, gaps 4, config 2
  localparam int TOTAL_ROUNDS = 23;
  localparam int TOTAL_STROBES = TOTAL_ROUNDS * `FM_NUM_SLOT;
  localparam int WATCHDOG_NS = TOTAL_STROBES * (MAX_GAP + 1) * 4 * 2;
  localparam int SND_MAX = (1 << (`FM_SND_W - 1)) - 1;
  localparam int SND_MIN = -(1 << (`FM_SND_W - 1));

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     clk_en;
  fm_audio_pkg::op_sample_t op_result;
  fm_slot_pkg::cfg_wr_t     cfg_wr;
  fm_audio_pkg::frame_t     frame;
  logic                     frame_valid;

  // Reference copy of the channel table and the round stimulus
  fm_slot_pkg::ch_cfg_t     tb_cfg [`FM_NUM_CH];
  fm_audio_pkg::op_sample_t res_buf [`FM_NUM_SLOT];
  fm_audio_pkg::frame_t     exp_q [$];
  fm_audio_pkg::frame_t     zero_f;

  logic [31:0] rng_state = 32'h2c72_b993;
  int          cyc = 0;
  int          exp_valid_cyc = -1;
  int          err_cnt = 0;
  int          err_at_start = 0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  string       cur_test = "init";

  fm_acc_top dut (
    .clk         (clk),
    .rst         (rst),
    .clk_en      (clk_en),
    .op_result   (op_result),
    .cfg_wr      (cfg_wr),
    .frame       (frame),
    .frame_valid (frame_valid)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic compare_value(input string what, input logic signed [31:0] expected,
                               input logic signed [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s %s expected %0d actual %0d", cur_test, what, expected, actual);
      err_cnt++;
    end
  endtask

  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Carrier operators per algorithm
  function automatic bit is_carrier(input logic [2:0] alg, input int op);
    case (alg)
      3'd0, 3'd1, 3'd2, 3'd3: return op == 3;
      3'd4: return (op == 1) || (op == 3);
      3'd5, 3'd6: return op != 0;
      default: return 1'b1;
    endcase
  endfunction

  task automatic accumulate(inout int sum, inout logic clip, input int value);
    int total;
    total = sum + value;
    if (total > SND_MAX) begin
      total = SND_MAX;
      clip = 1'b1;
    end else if (total < SND_MIN) begin
      total = SND_MIN;
      clip = 1'b1;
    end
    sum = total;
  endtask

  // Frame checker, sampled away from the rising edge
  always @(negedge clk) begin : monitor
    fm_audio_pkg::frame_t exp_f;
    if (!rst && frame_valid) begin
      compare_value("frame_valid cycle", exp_valid_cyc, cyc);
      if (exp_q.size() == 0) begin
        $display("Error: %s a frame arrived with no expected frame left", cur_test);
        err_cnt++;
      end else begin
        exp_f = exp_q.pop_front();
        compare_value("left", exp_f.left, frame.left);
        compare_value("right", exp_f.right, frame.right);
        compare_value("clip_l", exp_f.clip_l, frame.clip_l);
        compare_value("clip_r", exp_f.clip_r, frame.clip_r);
      end
    end else if (!rst && cyc == exp_valid_cyc) begin
      $display("Error: %s frame_valid did not pulse two cycles after slot 0", cur_test);
      err_cnt++;
    end
  end

  task automatic idle(input int n);
    repeat (n) begin
      @(negedge clk);
      clk_en = 1'b0;
      cfg_wr = '0;
    end
  endtask

  task automatic write_cfg(input int ch, input logic [2:0] alg, input logic [1:0] pan);
    fm_slot_pkg::cfg_wr_t wr;
    wr.we = 1'b1;
    wr.ch = 3'(ch);
    wr.cfg = {alg, pan};
    @(negedge clk);
    clk_en = 1'b0;
    cfg_wr = wr;
    tb_cfg[ch] = wr.cfg;
  endtask

  task automatic fill_random(input int bits);
    logic [31:0] r;
    int span;
    span = 1 << bits;
    for (int i = 0; i < `FM_NUM_SLOT; i++) begin
      r = xorshift32();
      res_buf[i] = fm_audio_pkg::op_sample_t'(int'(r % span) - span / 2);
    end
  endtask

  task automatic fill_const(input int value);
    for (int i = 0; i < `FM_NUM_SLOT; i++) begin
      res_buf[i] = fm_audio_pkg::op_sample_t'(value);
    end
  endtask

  // 24 strobes, optional config write in a gap after strobe wr_at
  task automatic run_round(input int gap, input bit rand_gap, input int wr_at,
                           input fm_slot_pkg::cfg_wr_t wr);
    fm_slot_pkg::ch_cfg_t cfg;
    fm_audio_pkg::frame_t exp_f;
    int sum_l;
    int sum_r;
    logic clip_l;
    logic clip_r;
    int value;
    int n_gap;
    logic [31:0] r;
    sum_l = 0;
    sum_r = 0;
    clip_l = 1'b0;
    clip_r = 1'b0;
    for (int i = 0; i < `FM_NUM_SLOT; i++) begin
      @(negedge clk);
      clk_en = 1'b1;
      cfg_wr = '0;
      op_result = res_buf[i];
      if (i == 0) begin
        exp_valid_cyc = cyc + 2;
      end
      cfg = tb_cfg[i / `FM_NUM_OP];
      value = is_carrier(cfg.alg, i % `FM_NUM_OP) ? int'(res_buf[i]) : 0;
      if (i == 0) begin
        sum_l = cfg.pan.left ? value : 0;
        sum_r = cfg.pan.right ? value : 0;
      end else begin
        accumulate(sum_l, clip_l, cfg.pan.left ? value : 0);
        accumulate(sum_r, clip_r, cfg.pan.right ? value : 0);
      end
      n_gap = rand_gap ? 1 + int'(xorshift32() % MAX_GAP) : gap;
      for (int g = 0; g < n_gap; g++) begin
        @(negedge clk);
        clk_en = 1'b0;
        cfg_wr = '0;
        // Noise on the result bus while idle
        r = xorshift32();
        op_result = r[13:0];
      end
      if (i == wr_at) begin
        @(negedge clk);
        clk_en = 1'b0;
        cfg_wr = wr;
        tb_cfg[wr.ch] = wr.cfg;
      end
    end
    exp_f.left = fm_audio_pkg::snd_t'(sum_l);
    exp_f.right = fm_audio_pkg::snd_t'(sum_r);
    exp_f.clip_l = clip_l;
    exp_f.clip_r = clip_r;
    exp_q.push_back(exp_f);
  endtask

  // Zero round whose slot 0 emits the previous round
  task automatic flush_round();
    fill_const(0);
    run_round(0, 1'b0, -1, '0);
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    err_at_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == err_at_start) begin
      pass_cnt++;
      $display("Test %s: ok", cur_test);
    end else begin
      fail_cnt++;
      $display("Test %s: failed with %0d errors", cur_test, err_cnt - err_at_start);
    end
  endtask

  task automatic test_reset();
    start_test("reset");
    idle(6);
    fill_random(13);
    run_round(0, 1'b0, -1, '0);
    flush_round();
    end_test();
  endtask

  task automatic test_algorithms();
    start_test("algorithms");
    for (int a = 0; a < 8; a++) begin
      for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
        write_cfg(ch, 3'(a), 2'b11);
      end
      fill_random(11);
      run_round(0, 1'b0, -1, '0);
    end
    flush_round();
    end_test();
  endtask

  task automatic test_pan();
    logic [1:0] pans [`FM_NUM_CH];
    pans = '{2'b10, 2'b01, 2'b11, 2'b00, 2'b10, 2'b01};
    start_test("pan");
    for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
      write_cfg(ch, 3'(ch + 2), pans[ch]);
    end
    fill_random(11);
    run_round(0, 1'b0, -1, '0);
    flush_round();
    end_test();
  endtask

  task automatic test_saturation();
    start_test("saturation");
    // Left saturates high, right gets one carrier
    for (int ch = 0; ch < `FM_NUM_CH - 1; ch++) begin
      write_cfg(ch, 3'd7, 2'b10);
    end
    write_cfg(`FM_NUM_CH - 1, 3'd0, 2'b01);
    fill_const(8000);
    run_round(0, 1'b0, -1, '0);
    // Right saturates low
    for (int ch = 0; ch < `FM_NUM_CH - 1; ch++) begin
      write_cfg(ch, 3'd7, 2'b01);
    end
    write_cfg(`FM_NUM_CH - 1, 3'd0, 2'b10);
    fill_const(-8000);
    run_round(0, 1'b0, -1, '0);
    fill_random(9);
    run_round(0, 1'b0, -1, '0);
    flush_round();
    end_test();
  endtask

  task automatic test_gaps();
    logic [31:0] r;
    start_test("strobe gaps");
    for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
      r = xorshift32();
      write_cfg(ch, r[2:0], r[4:3]);
    end
    fill_random(11);
    run_round(0, 1'b0, -1, '0);
    run_round(0, 1'b1, -1, '0);
    fill_random(11);
    run_round(0, 1'b1, -1, '0);
    flush_round();
    end_test();
  endtask

  task automatic test_cfg_change();
    fm_slot_pkg::cfg_wr_t wr;
    start_test("config change");
    for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
      write_cfg(ch, 3'd7, 2'b11);
    end
    // Channel 3 switches between its op 1 and op 2
    wr.we = 1'b1;
    wr.ch = 3'd3;
    wr.cfg = {3'd4, 2'b10};
    fill_random(11);
    run_round(0, 1'b0, 13, wr);
    flush_round();
    end_test();
  endtask

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Error: watchdog expired, the tests did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    rst = 1'b1;
    clk_en = 1'b0;
    op_result = '0;
    cfg_wr = '0;
    zero_f = '0;
    for (int ch = 0; ch < `FM_NUM_CH; ch++) begin
      tb_cfg[ch] = '0;
    end
    // First frame after reset carries an empty round
    exp_q.push_back(zero_f);
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset();
    test_algorithms();
    test_pan();
    test_saturation();
    test_gaps();
    test_cfg_change();
    idle(4);
    $display("Tests passed %0d, failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0 && fail_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+.
fm_slot_pkg.sv
fm_audio_pkg.sv
fm_slot_seq.sv
fm_single_acc.sv
fm_stereo_out.sv
fm_acc_top.sv
tb_fm_acc_top.sv
